//--- Makefile
TOP = tb_channel_addition_core
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

obj_dir/V$(TOP): verilog.f verilog/*.sv tb/*.sv
	verilator --binary --timing -f verilog.f --top-module $(TOP)

# the run itself may exit nonzero, the log decides
sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    localparam real HALF_PERIOD = 4.0;
    localparam int RST_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a rising edge so the first cycle is clean
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb/tb_channel_addition_core.sv
`timescale 1ns/1ps

module tb_channel_addition_core
    import chn_add_pkg::*;
();

    localparam int CLK_PERIOD_NS = 8;
    localparam int N_SINGLE = 6;
    localparam int N_ACC = 6;
    localparam int N_B2B = 10;
    // upper bound, accumulations use at most 5 and 3 groups
    localparam int MAX_GROUPS = N_SINGLE + 2 + N_ACC * 5 + N_B2B * 3;
    localparam int WATCHDOG_CYCLES = MAX_GROUPS * 20 + 200;

    logic      clk;
    logic      rst_n;
    logic      fms_data_vld;
    logic      psum_last;
    fms_bus_t  fms_data;
    logic      in_ready;
    logic      infms_data_vld;
    psum_bus_t infms_data;

    int        cyc = 0;
    // earliest edge that can take the next first slice
    int        next_accept = 0;
    string     test_name;
    logic [31:0] rng_state;

    // operands of the group being sent
    logic signed [7:0] cur_ops [NUM_PIX][NUM_CHN];

    // reference model state
    psum_t     model_acc [NUM_PIX];
    logic      model_fresh;
    psum_bus_t exp_data_q[$];
    int        exp_cyc_q[$];

    logic      mon_exp_vld;
    psum_bus_t mon_exp_bus;

    clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    channel_addition_core channel_addition_core_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fms_data_vld   (fms_data_vld),
        .psum_last      (psum_last),
        .fms_data       (fms_data),
        .in_ready       (in_ready),
        .infms_data_vld (infms_data_vld),
        .infms_data     (infms_data)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_psum(input string name, input int pix, input psum_t exp_val,
                              input psum_t act_val);
        if (act_val !== exp_val) begin
            report_failure($sformatf("FAILED %s pixel %0d: expected %0d actual %0d",
                                     name, pix, exp_val, act_val));
        end
    endtask

    task automatic check_flag(input string name, input string sig, input logic exp_val,
                              input logic act_val);
        if (act_val !== exp_val) begin
            report_failure($sformatf("FAILED %s %s: expected %b actual %b",
                                     name, sig, exp_val, act_val));
        end
    endtask

    task automatic fill_random();
        logic [31:0] r;
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int c = 0; c < NUM_CHN; c++) begin
                r = rand32();
                cur_ops[p][c] = r[7:0];
            end
        end
    endtask

    task automatic fill_const(input logic signed [7:0] v);
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int c = 0; c < NUM_CHN; c++) begin
                cur_ops[p][c] = v;
            end
        end
    endtask

    // slice s of every operand, slot p*NUM_CHN+c
    function automatic fms_bus_t slice_bus(input int s);
        fms_bus_t   b;
        logic [7:0] op;
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int c = 0; c < NUM_CHN; c++) begin
                op = cur_ops[p][c];
                b[(p*NUM_CHN + c)*SLICE_W +: SLICE_W] = op[s*SLICE_W +: SLICE_W];
            end
        end
        return b;
    endfunction

    // signed channel sums, accumulated until a last group
    task automatic update_model(input logic last, input int accept_cyc);
        int        chn_sum;
        psum_bus_t exp_bus;
        for (int p = 0; p < NUM_PIX; p++) begin
            chn_sum = 0;
            for (int c = 0; c < NUM_CHN; c++) begin
                chn_sum += int'(cur_ops[p][c]);
            end
            if (model_fresh) begin
                model_acc[p] = psum_t'(chn_sum);
            end else begin
                model_acc[p] = model_acc[p] + psum_t'(chn_sum);
            end
            exp_bus[p*PSUM_W +: PSUM_W] = model_acc[p];
        end
        model_fresh = last;
        if (last) begin
            exp_data_q.push_back(exp_bus);
            // pulse is high 8 edges after the first slice is taken
            exp_cyc_q.push_back(accept_cyc + 8);
        end
    endtask

    task automatic drive_group(input logic last);
        int accept_cyc;
        @(negedge clk);
        // slice 0 goes out at the next edge and is taken one edge later
        while (cyc + 2 < next_accept) begin
            @(negedge clk);
        end
        accept_cyc = cyc + 2;
        // four load slices and two extension slices per group
        next_accept = accept_cyc + SUM_SLICES;
        update_model(last, accept_cyc);
        for (int s = 0; s < OPERAND_SLICES; s++) begin
            @(posedge clk);
            fms_data_vld <= 1'b1;
            fms_data     <= slice_bus(s);
            psum_last    <= (s == 0) ? last : 1'b0;
            if (s == 0) begin
                // first slice must meet a ready feeder
                @(negedge clk);
                check_flag(test_name, "in_ready", 1'b1, in_ready);
            end
        end
        @(posedge clk);
        fms_data_vld <= 1'b0;
        psum_last    <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_cyc_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    ////////////////////
    // output monitor
    ////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            mon_exp_vld = (exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc);
            check_flag(test_name, "infms_data_vld", mon_exp_vld, infms_data_vld);
            if (mon_exp_vld) begin
                mon_exp_bus = exp_data_q.pop_front();
                void'(exp_cyc_q.pop_front());
                for (int p = 0; p < NUM_PIX; p++) begin
                    check_psum(test_name, p, psum_t'(mon_exp_bus[p*PSUM_W +: PSUM_W]),
                               psum_t'(infms_data[p*PSUM_W +: PSUM_W]));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog timeout after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("tests failed");
        $fatal(1, "run did not finish in time");
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int          n_grp;
        logic [31:0] r;
        fms_data_vld = 1'b0;
        psum_last    = 1'b0;
        fms_data     = '0;
        rng_state    = 32'd94;
        model_fresh  = 1'b1;
        for (int p = 0; p < NUM_PIX; p++) begin
            model_acc[p] = '0;
        end

        test_name = "reset";
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_flag(test_name, "in_ready", 1'b1, in_ready);
        check_flag(test_name, "infms_data_vld", 1'b0, infms_data_vld);

        test_name = "single";
        for (int i = 0; i < N_SINGLE; i++) begin
            fill_random();
            drive_group(1'b1);
            wait_drain();
        end

        // -1024 and 1016 per pixel
        test_name = "extreme";
        fill_const(-8'sd128);
        drive_group(1'b1);
        wait_drain();
        fill_const(8'sd127);
        drive_group(1'b1);
        wait_drain();

        test_name = "accumulate";
        for (int a = 0; a < N_ACC; a++) begin
            r = rand32();
            n_grp = 2 + int'(r[1:0]);
            for (int g = 0; g < n_grp; g++) begin
                fill_random();
                drive_group(g == n_grp - 1);
            end
            wait_drain();
        end

        // no drain between groups, each starts at the first edge the feeder can take it
        test_name = "back_to_back";
        for (int a = 0; a < N_B2B; a++) begin
            r = rand32();
            n_grp = 1 + int'(r[1:0] % 2'd3);
            for (int g = 0; g < n_grp; g++) begin
                fill_random();
                drive_group(g == n_grp - 1);
            end
        end
        wait_drain();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog.f
verilog/chn_add_pkg.sv
verilog/slice_feeder.sv
verilog/serial_adder_tree.sv
verilog/sum_deserializer.sv
verilog/psum_accumulator.sv
verilog/channel_addition_core.sv
tb/clk_gen.sv
tb/tb_channel_addition_core.sv

//--- verilog/channel_addition_core.sv
`timescale 1ns/1ps

module channel_addition_core
    import chn_add_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fms_data_vld,
    input  logic      psum_last,
    input  fms_bus_t  fms_data,
    output logic      in_ready,
    output logic      infms_data_vld,
    output psum_bus_t infms_data
);

    logic                 tree_vld;
    logic                 tree_first;
    logic                 tree_last;
    fms_bus_t             tree_slices;

    logic   [NUM_PIX-1:0] out_vld;
    slice_t [NUM_PIX-1:0] out_slice;

    // only pixel 0 flags go on, all pixels run in lockstep
    logic   [NUM_PIX-1:0] pix_sum_vld;
    logic   [NUM_PIX-1:0] pix_sum_last;
    sum_t   [NUM_PIX-1:0] sums;

    slice_feeder slice_feeder_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fms_data_vld (fms_data_vld),
        .fms_data     (fms_data),
        .psum_last    (psum_last),
        .in_ready     (in_ready),
        .tree_vld     (tree_vld),
        .tree_first   (tree_first),
        .tree_last    (tree_last),
        .tree_slices  (tree_slices)
    );

    ////////////////////
    // per pixel lanes
    ////////////////////

    for (genvar p = 0; p < NUM_PIX; p++) begin : g_pix
        serial_adder_tree serial_adder_tree_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_vld    (tree_vld),
            .in_first  (tree_first),
            .in_slices (tree_slices[p*NUM_CHN*SLICE_W +: NUM_CHN*SLICE_W]),
            .out_vld   (out_vld[p]),
            .out_slice (out_slice[p])
        );

        sum_deserializer sum_deserializer_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_vld   (out_vld[p]),
            .in_slice (out_slice[p]),
            .in_last  (tree_last),
            .sum_vld  (pix_sum_vld[p]),
            .sum_last (pix_sum_last[p]),
            .sum      (sums[p])
        );
    end

    psum_accumulator psum_accumulator_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .sum_vld        (pix_sum_vld[0]),
        .sum_last       (pix_sum_last[0]),
        .sums           (sums),
        .infms_data_vld (infms_data_vld),
        .infms_data     (infms_data)
    );

endmodule

//--- verilog/chn_add_pkg.sv
package chn_add_pkg;

    ////////////////////
    // datapath sizes
    ////////////////////

    // channels summed into one pixel
    localparam int NUM_CHN = 8;
    // pixels in one row
    localparam int NUM_PIX = 4;

    // serial slice width
    localparam int SLICE_W = 2;
    // slices of an 8-bit operand
    localparam int OPERAND_SLICES = 4;
    // two extra slices carry the sign extension
    localparam int SUM_SLICES = 6;

    // channel sum and accumulator widths
    localparam int SUM_W = 12;
    localparam int PSUM_W = 20;

    // tree carry, enough for eight slices plus itself
    localparam int CARRY_W = 3;
    // counts up to SUM_SLICES
    localparam int CNT_W = 3;

    ////////////////////
    // vector types
    ////////////////////

    typedef logic [SLICE_W-1:0] slice_t;

    // one pixel, channel c at bits c*SLICE_W
    typedef logic [NUM_CHN*SLICE_W-1:0] chn_slices_t;

    // whole row, slot p*NUM_CHN+c
    typedef logic [NUM_PIX*NUM_CHN*SLICE_W-1:0] fms_bus_t;

    typedef logic signed [SUM_W-1:0] sum_t;
    typedef logic signed [PSUM_W-1:0] psum_t;

    // pixel 0 in the low bits
    typedef logic [NUM_PIX*PSUM_W-1:0] psum_bus_t;

    // feeder FSM
    typedef enum logic [1:0] {
        feed_idle,
        feed_load,
        feed_extend
    } feed_state_t;

endpackage

//--- verilog/psum_accumulator.sv
`timescale 1ns/1ps

module psum_accumulator
    import chn_add_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sum_vld,
    input  logic                    sum_last,
    input  sum_t      [NUM_PIX-1:0] sums,
    output logic                    infms_data_vld,
    output psum_bus_t               infms_data
);

    psum_t acc [NUM_PIX];
    psum_t acc_nxt [NUM_PIX];
    // next sum starts a new accumulation
    logic  fresh;

    ////////////////////
    // add or load
    ////////////////////

    always_comb begin
        for (int p = 0; p < NUM_PIX; p++) begin
            if (fresh) begin
                acc_nxt[p] = psum_t'(sums[p]);
            end else begin
                acc_nxt[p] = acc[p] + psum_t'(sums[p]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fresh          <= 1'b1;
            infms_data_vld <= 1'b0;
            for (int p = 0; p < NUM_PIX; p++) begin
                acc[p] <= '0;
            end
        end else begin
            infms_data_vld <= sum_vld && sum_last;
            if (sum_vld) begin
                fresh <= sum_last;
                for (int p = 0; p < NUM_PIX; p++) begin
                    acc[p] <= acc_nxt[p];
                end
            end
        end
    end

    ////////////////////
    // output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (sum_vld && sum_last) begin
            for (int p = 0; p < NUM_PIX; p++) begin
                infms_data[p*PSUM_W +: PSUM_W] <= acc_nxt[p];
            end
        end
    end

endmodule

//--- verilog/serial_adder_tree.sv
`timescale 1ns/1ps

module serial_adder_tree
    import chn_add_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_vld,
    input  logic        in_first,
    input  chn_slices_t in_slices,
    output logic        out_vld,
    output slice_t      out_slice
);

    localparam int TOTAL_W = SLICE_W + CARRY_W;

    logic [CARRY_W-1:0] carry;
    logic [TOTAL_W-1:0] total;

    ////////////////////
    // slice sum
    ////////////////////

    // eight unsigned slices plus the carry of the previous slice
    always_comb begin
        if (in_first) begin
            total = '0;
        end else begin
            total = TOTAL_W'(carry);
        end
        for (int c = 0; c < NUM_CHN; c++) begin
            total = total + TOTAL_W'(in_slices[c*SLICE_W +: SLICE_W]);
        end
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
            carry   <= '0;
        end else begin
            out_vld <= in_vld;
            if (in_vld) begin
                // upper bits move on to the next slice
                carry <= total[TOTAL_W-1:SLICE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld) begin
            out_slice <= total[SLICE_W-1:0];
        end
    end

endmodule

//--- verilog/slice_feeder.sv
`timescale 1ns/1ps

module slice_feeder
    import chn_add_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fms_data_vld,
    input  fms_bus_t fms_data,
    input  logic     psum_last,
    output logic     in_ready,
    output logic     tree_vld,
    output logic     tree_first,
    output logic     tree_last,
    output fms_bus_t tree_slices
);

    feed_state_t      state;
    // slices already sent for the current group
    logic [CNT_W-1:0] cnt;
    logic             load_done;
    logic             ext_done;
    logic             start;
    fms_bus_t         ext_slices;

    assign load_done = (state == feed_load) && (cnt == CNT_W'(OPERAND_SLICES));
    assign ext_done  = (state == feed_extend) && (cnt == CNT_W'(SUM_SLICES));

    // no new group while the next edge still owes an extension slice
    assign in_ready = !load_done && !((state == feed_extend) && !ext_done);
    assign start    = fms_data_vld && ((state == feed_idle) || ext_done);

    // replicate the sign bit of every slot's top slice
    always_comb begin
        for (int k = 0; k < NUM_PIX*NUM_CHN; k++) begin
            ext_slices[k*SLICE_W +: SLICE_W] = {SLICE_W{tree_slices[k*SLICE_W + SLICE_W - 1]}};
        end
    end

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= feed_idle;
            cnt        <= '0;
            tree_vld   <= 1'b0;
            tree_first <= 1'b0;
            tree_last  <= 1'b0;
        end else begin
            tree_first <= 1'b0;
            if (start) begin
                state      <= feed_load;
                cnt        <= CNT_W'(1);
                tree_vld   <= 1'b1;
                tree_first <= 1'b1;
                tree_last  <= psum_last;
            end else begin
                case (state)
                    feed_load: begin
                        cnt <= cnt + 1'b1;
                        if (load_done) begin
                            state <= feed_extend;
                        end
                    end
                    feed_extend: begin
                        if (ext_done) begin
                            state    <= feed_idle;
                            tree_vld <= 1'b0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: begin
                        tree_vld <= 1'b0;
                    end
                endcase
            end
        end
    end

    // slice register, second extension cycle just holds
    always_ff @(posedge clk) begin
        if (start || ((state == feed_load) && !load_done)) begin
            tree_slices <= fms_data;
        end else if (load_done) begin
            tree_slices <= ext_slices;
        end
    end

endmodule

//--- verilog/sum_deserializer.sv
`timescale 1ns/1ps

module sum_deserializer
    import chn_add_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_vld,
    input  slice_t in_slice,
    input  logic   in_last,
    output logic   sum_vld,
    output logic   sum_last,
    output sum_t   sum
);

    logic [CNT_W-1:0] cnt;
    logic             last_q;
    logic             sum_done;

    assign sum_done = in_vld && (cnt == CNT_W'(SUM_SLICES - 1));

    ////////////////////
    // slice counter
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            last_q   <= 1'b0;
            sum_vld  <= 1'b0;
            sum_last <= 1'b0;
        end else begin
            sum_vld <= sum_done;
            if (in_vld) begin
                if (sum_done) begin
                    cnt <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            // flag belongs to the group whose first slice this is
            if (in_vld && (cnt == '0)) begin
                last_q <= in_last;
            end
            if (sum_done) begin
                sum_last <= last_q;
            end
        end
    end

    // lsb slice enters first, so shift in at the top
    always_ff @(posedge clk) begin
        if (in_vld) begin
            sum <= {in_slice, sum[SUM_W-1:SLICE_W]};
        end
    end

endmodule
